/* common/pcs_code_pkg.sv */
`default_nettype none

package pcs_code_pkg;

    // ------------------------------------------------------------
    // Code group layout
    // ------------------------------------------------------------
    localparam int CODE_WIDTH = 10;
    localparam int SUB6_WIDTH = 6;
    localparam int SUB4_WIDTH = 4;

    // abcdei in the upper bits, fghj in the lower bits
    typedef logic [CODE_WIDTH-1:0] code_group_t;
    typedef logic [SUB6_WIDTH-1:0] sub6_t;
    typedef logic [SUB4_WIDTH-1:0] sub4_t;

    // Comma idle K28.5 in both running-disparity forms
    localparam code_group_t IDLE_POS_RD = 10'h0FA;
    localparam code_group_t IDLE_NEG_RD = 10'h305;

    typedef struct packed {
        logic       valid;
        logic [4:0] value;
    } dec6_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] value;
    } dec4_t;

    // ------------------------------------------------------------
    // 5b/6b lookup
    // ------------------------------------------------------------
    function automatic dec6_t decode_6b(input sub6_t sb);
        dec6_t res;
        res.valid = 1'b1;
        case (sb)
            6'b100111, 6'b011000:            res.value = 5'd0;
            6'b011101, 6'b100010:            res.value = 5'd1;
            6'b101101, 6'b010010:            res.value = 5'd2;
            6'b110001:                       res.value = 5'd3;
            6'b110101, 6'b001010:            res.value = 5'd4;
            6'b101001:                       res.value = 5'd5;
            6'b011001:                       res.value = 5'd6;
            6'b111000, 6'b000111:            res.value = 5'd7;
            6'b111001, 6'b000110:            res.value = 5'd8;
            6'b100101:                       res.value = 5'd9;
            6'b010101:                       res.value = 5'd10;
            6'b110100:                       res.value = 5'd11;
            6'b001101:                       res.value = 5'd12;
            6'b101100:                       res.value = 5'd13;
            6'b011100:                       res.value = 5'd14;
            6'b010111, 6'b101000:            res.value = 5'd15;
            6'b011011, 6'b100100:            res.value = 5'd16;
            6'b100011:                       res.value = 5'd17;
            6'b010011:                       res.value = 5'd18;
            6'b110010:                       res.value = 5'd19;
            6'b001011:                       res.value = 5'd20;
            6'b101010:                       res.value = 5'd21;
            6'b011010:                       res.value = 5'd22;
            6'b111010, 6'b000101:            res.value = 5'd23;
            6'b110011, 6'b001100:            res.value = 5'd24;
            6'b100110:                       res.value = 5'd25;
            6'b010110:                       res.value = 5'd26;
            6'b110110, 6'b001001:            res.value = 5'd27;
            // D.28 plus both K.28 forms
            6'b001110, 6'b001111, 6'b110000: res.value = 5'd28;
            6'b101110, 6'b010001:            res.value = 5'd29;
            6'b011110, 6'b100001:            res.value = 5'd30;
            6'b101011, 6'b010100:            res.value = 5'd31;
            default: begin
                res.valid = 1'b0;
                res.value = 5'd0;
            end
        endcase
        return res;
    endfunction

    // ------------------------------------------------------------
    // 3b/4b lookup
    // ------------------------------------------------------------
    function automatic dec4_t decode_4b(input sub4_t sb);
        dec4_t res;
        res.valid = 1'b1;
        case (sb)
            4'b1011, 4'b0100:                   res.value = 3'd0;
            4'b1001:                            res.value = 3'd1;
            4'b0101:                            res.value = 3'd2;
            4'b1100, 4'b0011:                   res.value = 3'd3;
            4'b1101, 4'b0010:                   res.value = 3'd4;
            4'b1010:                            res.value = 3'd5;
            4'b0110:                            res.value = 3'd6;
            // Primary and alternate x.7 forms
            4'b1110, 4'b0001, 4'b0111, 4'b1000: res.value = 3'd7;
            default: begin
                res.valid = 1'b0;
                res.value = 3'd0;
            end
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

/* common/pcs_link_pkg.sv */
`default_nettype none

package pcs_link_pkg;

    typedef logic [7:0] octet_t;

    // Decoded value of the /T/ group (K29.7)
    localparam octet_t TERMINATE_OCTET = 8'hFD;

    // ------------------------------------------------------------
    // Link silence detection
    // ------------------------------------------------------------
    // Cycles without PMA valid before the link counts as silent
    localparam int LINK_TIMEOUT = 31;
    localparam int TIMEOUT_CNT_WIDTH = $clog2(LINK_TIMEOUT + 1);

    typedef logic [TIMEOUT_CNT_WIDTH-1:0] timeout_cnt_t;

endpackage

`default_nettype wire

/* common/rx_sym_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface rx_sym_if;

    import pcs_link_pkg::*;

    // Only meaningful while sym_valid is high
    logic   sym_valid;
    octet_t sym_octet;
    logic   sym_idle;
    logic   sym_code_err;

    modport src (
        output sym_valid,
        output sym_octet,
        output sym_idle,
        output sym_code_err
    );

    modport dst (
        input  sym_valid,
        input  sym_octet,
        input  sym_idle,
        input  sym_code_err
    );

    // Link monitor only looks at error status
    modport mon (
        input  sym_valid,
        input  sym_code_err
    );

endinterface

`default_nettype wire

/* decode/pcs_symbol_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module pcs_symbol_decoder (
    input  wire logic                      clk_125m,
    input  wire logic                      rst_125m,
    input  wire logic                      pma_dval,
    input  wire pcs_code_pkg::code_group_t pma_code,
    rx_sym_if.src                          sym
);

    import pcs_code_pkg::*;
    import pcs_link_pkg::*;

    logic        code_vld_q;
    code_group_t code_q;
    dec6_t       dec6;
    dec4_t       dec4;
    logic        is_idle;
    logic        is_bad;
    octet_t      dec_octet;

    // ------------------------------------------------------------
    // Input stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            code_vld_q <= 1'b0;
        end else begin
            code_vld_q <= pma_dval;
        end
    end

    always_ff @(posedge clk_125m) begin
        if (pma_dval) begin
            code_q <= pma_code;
        end
    end

    // ------------------------------------------------------------
    // Lookup and classification
    // ------------------------------------------------------------
    always_comb begin
        dec6      = decode_6b(code_q[CODE_WIDTH-1 -: SUB6_WIDTH]);
        dec4      = decode_4b(code_q[SUB4_WIDTH-1:0]);
        is_idle   = (code_q == IDLE_POS_RD) || (code_q == IDLE_NEG_RD);
        // Idle forms are legal sub-blocks, so this never overlaps is_idle
        is_bad    = !(dec6.valid && dec4.valid);
        // HGF from the 4b side, EDCBA from the 6b side
        dec_octet = is_bad ? '0 : {dec4.value, dec6.value};
    end

    // ------------------------------------------------------------
    // Symbol output stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            sym.sym_valid    <= 1'b0;
            sym.sym_idle     <= 1'b0;
            sym.sym_code_err <= 1'b0;
        end else begin
            sym.sym_valid    <= code_vld_q;
            sym.sym_idle     <= code_vld_q && is_idle;
            sym.sym_code_err <= code_vld_q && is_bad;
        end
    end

    always_ff @(posedge clk_125m) begin
        if (code_vld_q) begin
            sym.sym_octet <= dec_octet;
        end
    end

endmodule

`default_nettype wire

/* framing/pcs_frame_delimiter.sv */
`timescale 1ns/1ns
`default_nettype none

module pcs_frame_delimiter (
    input  wire logic            clk_125m,
    input  wire logic            rst_125m,
    rx_sym_if.dst                sym,
    output logic                 mac_dval,
    output logic                 mac_sop,
    output logic                 mac_eop,
    output pcs_link_pkg::octet_t mac_data
);

    import pcs_link_pkg::*;

    logic   sym_accept;
    logic   sym_is_data;
    logic   release_now;
    logic   link_synced;
    logic   first_pend;
    logic   pend_vld;
    logic   pend_sop;
    octet_t pend_octet;

    // Invalid groups vanish from the stream here
    assign sym_accept  = sym.sym_valid && !sym.sym_code_err;
    assign sym_is_data = sym_accept && !sym.sym_idle;
    // Next good symbol tells us what the held octet is
    assign release_now = sym_accept && pend_vld;

    // ------------------------------------------------------------
    // Framing state
    // ------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            link_synced <= 1'b0;
            first_pend  <= 1'b0;
            pend_vld    <= 1'b0;
            pend_sop    <= 1'b0;
        end else if (sym_accept) begin
            if (sym.sym_idle) begin
                link_synced <= 1'b1;
                first_pend  <= 1'b1;
                pend_vld    <= 1'b0;
            end else if (link_synced) begin
                pend_vld    <= 1'b1;
                pend_sop    <= first_pend;
                first_pend  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_125m) begin
        if (sym_is_data) begin
            pend_octet <= sym.sym_octet;
        end
    end

    // ------------------------------------------------------------
    // MAC side
    // ------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            mac_dval <= 1'b0;
            mac_sop  <= 1'b0;
            mac_eop  <= 1'b0;
        end else begin
            mac_dval <= release_now;
            mac_sop  <= release_now && pend_sop;
            // Terminate only counts when idle follows it
            mac_eop  <= release_now && sym.sym_idle && (pend_octet == TERMINATE_OCTET);
        end
    end

    always_ff @(posedge clk_125m) begin
        if (release_now) begin
            mac_data <= pend_octet;
        end
    end

endmodule

`default_nettype wire

/* verilog/pcs_link_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module pcs_link_monitor (
    input  wire logic clk_125m,
    input  wire logic rst_125m,
    input  wire logic pma_dval,
    rx_sym_if.mon     sym,
    output logic      pcs_err
);

    import pcs_link_pkg::*;

    timeout_cnt_t silent_cnt;
    logic         link_silent;
    logic         code_err_hold;
    logic         code_err_now;

    assign link_silent  = (silent_cnt == timeout_cnt_t'(LINK_TIMEOUT));
    // Flag follows each valid symbol, otherwise keeps its last value
    assign code_err_now = sym.sym_valid ? sym.sym_code_err : code_err_hold;

    // ------------------------------------------------------------
    // Silence counter, saturating
    // ------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            silent_cnt <= '0;
        end else if (pma_dval) begin
            silent_cnt <= '0;
        end else if (!link_silent) begin
            silent_cnt <= silent_cnt + timeout_cnt_t'(1);
        end
    end

    // ------------------------------------------------------------
    // Error output
    // ------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            code_err_hold <= 1'b0;
            pcs_err       <= 1'b0;
        end else begin
            code_err_hold <= code_err_now;
            pcs_err       <= code_err_now || link_silent;
        end
    end

endmodule

`default_nettype wire

/* verilog/pcs_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_top (
    input  wire logic                      clk_125m,
    input  wire logic                      rst_125m,
    // PMA side
    input  wire logic                      pma_dval,
    input  wire pcs_code_pkg::code_group_t pma_code,
    // MAC side
    output logic                           mac_dval,
    output logic                           mac_sop,
    output logic                           mac_eop,
    output pcs_link_pkg::octet_t           mac_data,
    output logic                           pcs_err
);

    // Decoded symbol stream shared by framing and monitoring
    rx_sym_if sym_bus ();

    pcs_symbol_decoder u_decoder (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .pma_dval (pma_dval),
        .pma_code (pma_code),
        .sym      (sym_bus.src)
    );

    pcs_frame_delimiter u_delimiter (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .sym      (sym_bus.dst),
        .mac_dval (mac_dval),
        .mac_sop  (mac_sop),
        .mac_eop  (mac_eop),
        .mac_data (mac_data)
    );

    // Silence is judged on the raw PMA strobe
    pcs_link_monitor u_monitor (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .pma_dval (pma_dval),
        .sym      (sym_bus.mon),
        .pcs_err  (pcs_err)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_125m,
    output logic rst_125m
);

    localparam int HALF_PERIOD = 4;

    initial begin
        clk_125m = 1'b0;
        forever #HALF_PERIOD clk_125m = ~clk_125m;
    end

    // Release on a falling edge, clear of the DUT sampling edge
    initial begin
        rst_125m = 1'b0;
        repeat (10) @(posedge clk_125m);
        @(negedge clk_125m);
        rst_125m = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/pcs_rx_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_asserts (
    input wire logic clk_125m,
    input wire logic rst_125m,
    input wire logic pma_dval,
    input wire logic mac_dval,
    input wire logic mac_sop,
    input wire logic mac_eop,
    input wire logic pcs_err
);

    import pcs_link_pkg::*;

    timeout_cnt_t quiet_run;
    int           assert_fails = 0;

    // Consecutive cycles without PMA valid, saturating
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            quiet_run <= '0;
        end else if (pma_dval) begin
            quiet_run <= '0;
        end else if (quiet_run != timeout_cnt_t'(LINK_TIMEOUT)) begin
            quiet_run <= quiet_run + timeout_cnt_t'(1);
        end
    end

    sop_needs_dval: assert property (
        @(posedge clk_125m) disable iff (!rst_125m) mac_sop |-> mac_dval
    ) else begin
        assert_fails++;
        $error("mac_sop seen without mac_dval");
    end

    eop_needs_dval: assert property (
        @(posedge clk_125m) disable iff (!rst_125m) mac_eop |-> mac_dval
    ) else begin
        assert_fails++;
        $error("mac_eop seen without mac_dval");
    end

    // A rise needs a group three cycles back or a long silence
    err_needs_cause: assert property (
        @(posedge clk_125m) disable iff (!rst_125m)
        $rose(pcs_err) |-> ($past(pma_dval, 3) || ($past(quiet_run) >= LINK_TIMEOUT))
    ) else begin
        assert_fails++;
        $error("pcs_err rose with no code group or silence behind it");
    end

    quiet_after_reset: assert property (
        @(posedge clk_125m) $rose(rst_125m) |-> !mac_dval ##1 !mac_dval
    ) else begin
        assert_fails++;
        $error("mac_dval high right after reset");
    end

endmodule

bind pcs_rx_top pcs_rx_asserts u_asserts (
    .clk_125m (clk_125m),
    .rst_125m (rst_125m),
    .pma_dval (pma_dval),
    .mac_dval (mac_dval),
    .mac_sop  (mac_sop),
    .mac_eop  (mac_eop),
    .pcs_err  (pcs_err)
);

`default_nettype wire

/* verification/tb_pcs_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pcs_rx;

    import pcs_code_pkg::*;
    import pcs_link_pkg::*;

    localparam int unsigned SEED = 11572;
    localparam int NUM_FRAMES = 12;

    // 5b/6b and 3b/4b codes for negative running disparity
    localparam logic [5:0] ENC6_NEG [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    localparam logic [3:0] ENC4_NEG [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };

    typedef struct packed {
        logic   sop;
        logic   eop;
        octet_t data;
    } beat_t;

    logic        clk_125m;
    logic        rst_125m;
    logic        pma_dval;
    code_group_t pma_code;
    logic        mac_dval;
    logic        mac_sop;
    logic        mac_eop;
    octet_t      mac_data;
    logic        pcs_err;

    // Encoder disparity and reference model state
    logic        rd_pos;
    logic        synced;
    logic        first_octet;
    logic        pend_vld;
    logic        pend_sop;
    octet_t      pend_octet;
    beat_t       exp_q[$];

    int          err_count;
    int          timeout_count;
    int          beat_count;
    int          eop_count;

    tb_clock_gen clock_gen (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m)
    );

    pcs_rx_top UUT (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .pma_dval (pma_dval),
        .pma_code (pma_code),
        .mac_dval (mac_dval),
        .mac_sop  (mac_sop),
        .mac_eop  (mac_eop),
        .mac_data (mac_data),
        .pcs_err  (pcs_err)
    );

    // ------------------------------------------------------------
    // 8b/10b encoder
    // ------------------------------------------------------------
    task automatic encode_data(input octet_t oct, output code_group_t cg);
        logic [4:0] x;
        logic [2:0] y;
        logic [5:0] s6;
        logic [3:0] s4;
        logic       alt;
        x  = oct[4:0];
        y  = oct[7:5];
        s6 = ENC6_NEG[x];
        if (rd_pos && (($countones(s6) != 3) || (x == 5'd7))) begin
            s6 = ~s6;
        end
        if ($countones(s6) != 3) begin
            rd_pos = !rd_pos;
        end
        // Alternate x.7 avoids a run of five equal bits
        alt = (y == 3'd7) && ((!rd_pos && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                              (rd_pos && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
        s4 = alt ? 4'b0111 : ENC4_NEG[y];
        if (rd_pos && (($countones(s4) != 2) || (y == 3'd3))) begin
            s4 = ~s4;
        end
        if ($countones(s4) != 2) begin
            rd_pos = !rd_pos;
        end
        cg = {s6, s4};
    endtask

    // ------------------------------------------------------------
    // Reference model of the MAC stream
    // ------------------------------------------------------------
    task automatic predict_symbol(input logic is_idle, input octet_t oct);
        beat_t b;
        if (pend_vld) begin
            b.data = pend_octet;
            b.sop  = pend_sop;
            b.eop  = is_idle && (pend_octet == TERMINATE_OCTET);
            exp_q.push_back(b);
            pend_vld = 1'b0;
        end
        if (is_idle) begin
            synced      = 1'b1;
            first_octet = 1'b1;
        end else if (synced) begin
            pend_vld    = 1'b1;
            pend_octet  = oct;
            pend_sop    = first_octet;
            first_octet = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // PMA side drivers
    // ------------------------------------------------------------
    task automatic send_code(input code_group_t cg);
        @(negedge clk_125m);
        pma_dval = 1'b1;
        pma_code = cg;
    endtask

    task automatic drive_gap();
        @(negedge clk_125m);
        pma_dval = 1'b0;
        pma_code = code_group_t'($urandom);
    endtask

    task automatic maybe_gap();
        if (($urandom % 8) == 0) begin
            drive_gap();
        end
    endtask

    task automatic send_octet(input octet_t oct);
        code_group_t cg;
        encode_data(oct, cg);
        send_code(cg);
        predict_symbol(1'b0, oct);
    endtask

    // Both K28.5 forms flip the running disparity
    task automatic send_idle();
        send_code(rd_pos ? 10'b1100000101 : 10'b0011111010);
        rd_pos = !rd_pos;
        predict_symbol(1'b1, 8'h00);
    endtask

    // K29.7 is balanced
    task automatic send_terminate();
        send_code(rd_pos ? 10'b0100010111 : 10'b1011101000);
        predict_symbol(1'b0, TERMINATE_OCTET);
    endtask

    // ------------------------------------------------------------
    // Error scenarios
    // ------------------------------------------------------------
    task automatic inject_invalid();
        int n;
        code_group_t bad;
        case ($urandom % 3)
            0:       bad = 10'b0000000000;
            1:       bad = 10'b1111111111;
            default: bad = 10'b1001111111;
        endcase
        if (pcs_err !== 1'b0) begin
            err_count++;
            $display("ERR %0t: pcs_err already high before invalid group", $time);
        end
        send_code(bad);
        n = 0;
        while (pcs_err !== 1'b1 && n < 3) begin
            drive_gap();
            n++;
        end
        if (pcs_err !== 1'b1) begin
            timeout_count++;
            $display("Timeout at %0t: pcs_err did not rise after an invalid group", $time);
        end
        send_octet(octet_t'($urandom));
        n = 0;
        while (pcs_err !== 1'b0 && n < 4) begin
            drive_gap();
            n++;
        end
        if (pcs_err !== 1'b0) begin
            timeout_count++;
            $display("Timeout at %0t: pcs_err stayed high after a clean group", $time);
        end
    endtask

    task automatic check_silence();
        int n;
        int rose_at;
        if (pcs_err !== 1'b0) begin
            err_count++;
            $display("ERR %0t: pcs_err high before link silence", $time);
        end
        rose_at = -1;
        for (n = 1; n <= 40; n++) begin
            drive_gap();
            if (pcs_err === 1'b1 && rose_at < 0) begin
                rose_at = n;
            end
        end
        if (rose_at < 0 || rose_at > 33 || pcs_err !== 1'b1) begin
            err_count++;
            $display("ERR %0t: pcs_err not raised by 40 silent cycles (rose at %0d)",
                     $time, rose_at);
        end
        send_idle();
        n = 0;
        while (pcs_err !== 1'b0 && n < 2) begin
            send_idle();
            n++;
        end
        if (pcs_err !== 1'b0) begin
            timeout_count++;
            $display("Timeout at %0t: pcs_err stayed high after traffic resumed", $time);
        end
    endtask

    // ------------------------------------------------------------
    // MAC side checker
    // ------------------------------------------------------------
    task automatic check_beat();
        beat_t exp;
        if (exp_q.size() == 0) begin
            err_count++;
            $display("ERR %0t: unexpected MAC octet %02h", $time, mac_data);
        end else begin
            exp = exp_q.pop_front();
            beat_count++;
            if (mac_data !== exp.data || mac_sop !== exp.sop || mac_eop !== exp.eop) begin
                err_count++;
                $display("ERR %0t: got %02h sop %b eop %b, expected %02h sop %b eop %b",
                         $time, mac_data, mac_sop, mac_eop, exp.data, exp.sop, exp.eop);
            end
        end
        if (mac_eop === 1'b1) begin
            eop_count++;
        end
    endtask

    always @(negedge clk_125m) begin
        if (rst_125m === 1'b1 && mac_dval === 1'b1) begin
            check_beat();
        end
    end

    task automatic run_traffic();
        int len;
        int i;
        int n;
        octet_t oct;
        // Nothing is framed before the first idle
        repeat (3) send_octet(octet_t'($urandom));
        repeat (8) send_idle();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            len = 1 + ($urandom % 16);
            for (i = 0; i < len; i++) begin
                maybe_gap();
                oct = octet_t'($urandom);
                if (($urandom % 10) == 0) begin
                    oct = TERMINATE_OCTET;
                end
                send_octet(oct);
                if ((f == 3 || f == 7) && i == 0) begin
                    inject_invalid();
                end
            end
            maybe_gap();
            send_terminate();
            repeat (2 + ($urandom % 4)) begin
                maybe_gap();
                send_idle();
            end
            if (f == 5) begin
                check_silence();
            end
        end
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            drive_gap();
            n++;
        end
        repeat (4) drive_gap();
        if (exp_q.size() != 0) begin
            timeout_count++;
            $display("Timeout: %0d expected octets never reached the MAC", exp_q.size());
        end
        if (eop_count != NUM_FRAMES || pcs_err !== 1'b0) begin
            err_count++;
            $display("ERR %0t: %0d frame ends seen, expected %0d, pcs_err %b",
                     $time, eop_count, NUM_FRAMES, pcs_err);
        end
    endtask

    task automatic finish_run();
        // Bound assertion failures count as errors too
        err_count = err_count + UUT.u_asserts.assert_fails;
        $display("Summary: %0d errors, %0d timeouts, %0d octets checked, %0d frames",
                 err_count, timeout_count, beat_count, eop_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin : main
        int n;
        pma_dval      = 1'b0;
        pma_code      = '0;
        rd_pos        = 1'b0;
        synced        = 1'b0;
        first_octet   = 1'b0;
        pend_vld      = 1'b0;
        pend_sop      = 1'b0;
        pend_octet    = '0;
        err_count     = 0;
        timeout_count = 0;
        beat_count    = 0;
        eop_count     = 0;
        void'($urandom(SEED));
        n = 0;
        while (rst_125m !== 1'b1 && n < 40) begin
            @(negedge clk_125m);
            n++;
        end
        if (rst_125m !== 1'b1) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end else begin
            run_traffic();
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* files.f */
common/pcs_code_pkg.sv
common/pcs_link_pkg.sv
common/rx_sym_if.sv
decode/pcs_symbol_decoder.sv
framing/pcs_frame_delimiter.sv
verilog/pcs_link_monitor.sv
verilog/pcs_rx_top.sv
verification/tb_clock_gen.sv
verification/pcs_rx_asserts.sv
verification/tb_pcs_rx.sv
